// ==== Bender.yml ====
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_tag_array.sv
  - src/dcache_data_sram.sv
  - src/dcache_lane_mux.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - sim/dcache_mem_model.sv
      - sim/tb_dcache.sv

// ==== sim/dcache_mem_model.sv ====
module dcache_mem_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mem_req,
    input  dcache_pkg::mem_req_t          mem_data,
    output logic                          mem_ack,
    output logic [dcache_pkg::DATA_W-1:0] mem_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0]  store [logic [63:0]]; // sparse byte store.
    logic [63:0] rng;

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        y = y ^ (y << 17);
        return y;
    endfunction

    // contents of a word nobody has written.
    function automatic logic [63:0] unwritten_word(input logic [63:0] addr);
        return {addr[31:0], ~addr[63:32]} ^ 64'h0123_4567_89ab_cdef;
    endfunction

    function automatic logic [63:0] read_word(input logic [63:0] base);
        logic [63:0] word;
        word = unwritten_word(base);
        for (int b = 0; b < 8; b++) begin
            if (store.exists(base + b)) begin
                word[b*8 +: 8] = store[base + b];
            end
        end
        return word;
    endfunction

    task automatic serve(input dcache_pkg::mem_req_t r);
        int          delay;
        logic [63:0] base;
        rng   = xorshift(rng);
        delay = 1 + int'(rng % 6);
        base  = {r.addr.flat[63:3], 3'b000};
        if (r.we) begin
            for (int b = 0; b < 8; b++) begin
                if (r.mask[b]) begin
                    store[base + b] = r.wdata[b*8 +: 8];
                end
            end
        end
        repeat (delay - 1) @(posedge clk);
        #2;
        mem_ack   = 1'b1;
        mem_rdata = r.we ? 64'h0 : read_word(base);
        @(posedge clk);
        #2;
        mem_ack   = 1'b0;
        mem_rdata = '0;
    endtask

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        rng       = 64'd97198;
        forever begin
            @(posedge clk);
            if (rst && mem_req) begin
                serve(mem_data);
            end
        end
    end

endmodule

// ==== sim/tb_dcache.sv ====
module tb_dcache;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          N_TESTS     = 18;
    localparam int          WATCHDOG_NS = (N_TESTS * 20 + 4) * 20;
    localparam logic [63:0] CBASE       = 64'h0000_0000_8000_0000;
    localparam logic [63:0] CLIMIT      = 64'h0000_0000_8fff_ffff;

    typedef struct packed {
        logic        we;
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  mask;
        logic        mem_access;
    } stim_t;

    // A, B and C share index 8, U is below the cached range.
    stim_t stim [N_TESTS] = '{
        '{1'b0, 64'h0000_0000_8000_0040, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_8000_0040, 64'h0, 8'h00, 1'b0},
        '{1'b1, 64'h0000_0000_8000_0040, 64'h1111_2222_3333_4444, 8'h0f, 1'b1},
        '{1'b0, 64'h0000_0000_8000_0040, 64'h0, 8'h00, 1'b0},
        '{1'b0, 64'h0000_0000_8000_0240, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_8000_0440, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_8000_0040, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_8000_0240, 64'h0, 8'h00, 1'b0},
        '{1'b1, 64'h0000_0000_8000_0240, 64'haaaa_bbbb_cccc_dddd, 8'h81, 1'b1},
        '{1'b0, 64'h0000_0000_8000_0240, 64'h0, 8'h00, 1'b0},
        '{1'b0, 64'h0000_0000_4000_0100, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_4000_0100, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_9000_0008, 64'h0, 8'h00, 1'b1},
        '{1'b1, 64'h0000_0000_8000_1000, 64'h5555_6666_7777_8888, 8'hf0, 1'b1},
        '{1'b0, 64'h0000_0000_8000_1000, 64'h0, 8'h00, 1'b1},
        '{1'b0, 64'h0000_0000_8000_1000, 64'h0, 8'h00, 1'b0},
        '{1'b1, 64'h0000_0000_4000_0100, 64'h0123_4567_89ab_cdef, 8'h3c, 1'b1},
        '{1'b0, 64'h0000_0000_4000_0100, 64'h0, 8'h00, 1'b1}
    };

    logic                          clk;
    logic                          rst;
    logic                          req;
    dcache_pkg::dcache_req_t       req_data;
    logic                          resp_valid;
    logic [dcache_pkg::DATA_W-1:0] rdata;
    logic                          busy;
    logic                          mem_req;
    dcache_pkg::mem_req_t          mem_data;
    logic                          mem_ack;
    logic [dcache_pkg::DATA_W-1:0] mem_rdata;

    bit          ref_valid [2][64];
    logic [54:0] ref_tag   [2][64];
    logic [63:0] ref_mem   [logic [63:0]]; // word store, aligned keys.

    dcache_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .busy       (busy),
        .mem_req    (mem_req),
        .mem_data   (mem_data),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    dcache_mem_model mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_data  (mem_data),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the DUT stopped answering requests");
        $display("Regression failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] initial_word(input logic [63:0] addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return {addr[31:0], ~addr[63:32]} ^ 64'h0123_4567_89ab_cdef;
    endfunction

    // write-through keeps memory exact, so reads always return the memory word.
    task automatic predict(input stim_t s, output logic access, output logic [63:0] data);
        logic        cacheable;
        logic [5:0]  idx;
        logic [54:0] tag;
        int          way;
        logic [63:0] word;
        cacheable = (s.addr >= CBASE) && (s.addr <= CLIMIT);
        idx       = s.addr[8:3];
        tag       = s.addr[63:9];
        way       = -1;
        word      = initial_word(s.addr);
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == tag) begin
                way = w;
            end
        end
        if (s.we) begin
            for (int b = 0; b < 8; b++) begin
                if (s.mask[b]) begin
                    word[b*8 +: 8] = s.wdata[b*8 +: 8];
                end
            end
            ref_mem[s.addr] = word;
            access = 1'b1;
            data   = 64'h0;
        end else begin
            access = !(cacheable && way >= 0);
            data   = word;
            if (cacheable && way < 0) begin
                way = (ref_valid[0][idx] && !ref_valid[1][idx]) ? 1 : 0; // way 0 is the victim.
                ref_valid[way][idx] = 1'b1;
                ref_tag[way][idx]   = tag;
            end
        end
    endtask

    task automatic run_entry(input int n, input stim_t s);
        logic                 exp_access;
        logic [63:0]          exp_data;
        int                   cycles;
        int                   mem_reqs;
        dcache_pkg::mem_req_t seen;
        predict(s, exp_access, exp_data);
        if (exp_access !== s.mem_access) begin
            $display("entry %0d of the stimulus table contradicts the reference model", n);
            $display("Regression failed");
            $fatal(1);
        end
        req                = 1'b1;
        req_data.we        = s.we;
        req_data.addr.flat = s.addr;
        req_data.wdata     = s.wdata;
        req_data.mask      = s.mask;
        @(posedge clk);
        #2;
        req      = 1'b0;
        cycles   = 1;
        mem_reqs = 0;
        @(posedge clk);
        while (!resp_valid) begin
            check("busy", busy, 1'b1);
            if (mem_req) begin
                mem_reqs++;
                seen = mem_data;
            end
            cycles++;
            @(posedge clk);
        end
        check("mem_req", mem_reqs, exp_access ? 1 : 0);
        if (!exp_access) begin
            check("resp_valid cycle", cycles, 2); // hit answers two cycles after req.
        end else begin
            check("mem_data.we", seen.we, s.we);
            check("mem_data.addr", seen.addr.flat, s.addr);
            if (s.we) begin
                check("mem_data.mask", seen.mask, s.mask);
                check("mem_data.wdata", seen.wdata, s.wdata);
            end
        end
        check("rdata", rdata, exp_data);
    endtask

    initial begin
        rst      = 1'b0;
        req      = 1'b0;
        req_data = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        check("resp_valid", resp_valid, 1'b0);
        check("mem_req", mem_req, 1'b0);
        check("busy", busy, 1'b0);
        for (int n = 0; n < N_TESTS; n++) begin
            run_entry(n, stim[n]);
            #2;
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== src.f ====
src/dcache_pkg.sv
src/dcache_tag_array.sv
src/dcache_data_sram.sv
src/dcache_lane_mux.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/dcache_mem_model.sv
sim/tb_dcache.sv

// ==== src/dcache_ctrl.sv ====
module dcache_ctrl #(
    parameter logic [63:0] CACHE_BASE  = 64'h0000_0000_8000_0000,
    parameter logic [63:0] CACHE_LIMIT = 64'h0000_0000_8fff_ffff
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req,
    input  dcache_pkg::dcache_req_t         req_data,
    output logic                            resp_valid,
    output logic [dcache_pkg::DATA_W-1:0]   rdata,
    output logic                            busy,
    output logic                            mem_req,
    output dcache_pkg::mem_req_t            mem_data,
    input  logic                            mem_ack,
    input  logic [dcache_pkg::DATA_W-1:0]   mem_rdata,
    output logic [dcache_pkg::INDEX_W-1:0]  rd_index,
    input  dcache_pkg::way_sel_t            hit,
    input  dcache_pkg::way_sel_t            fill_way,
    output dcache_pkg::way_sel_t            tag_fill,
    output logic [dcache_pkg::TAG_W-1:0]    tag_value,
    output dcache_pkg::way_sel_t            wr_way,
    output logic                            wr_is_fill,
    output logic [dcache_pkg::DATA_W-1:0]   wr_data,
    output logic [dcache_pkg::DATA_W/8-1:0] wr_mask,
    input  logic [dcache_pkg::DATA_W-1:0]   lane_rdata
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        RESPOND
    } state_t;

    state_t                  state;
    dcache_pkg::dcache_req_t req_q;
    dcache_pkg::way_sel_t    hit_q;
    dcache_pkg::way_sel_t    fill_way_q;
    logic                    fill_pend;
    logic                    mem_req_q;
    logic                    cacheable;

    assign cacheable = (req_q.addr.flat >= CACHE_BASE) && (req_q.addr.flat <= CACHE_LIMIT);

    // sram and tags see the new index on the req cycle.
    assign rd_index  = req ? req_data.addr.fld.index : req_q.addr.fld.index;
    assign tag_value = req_q.addr.fld.tag;

    always_ff @(posedge clk) begin
        if (req && state == IDLE) begin
            req_q <= req_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= IDLE;
            hit_q      <= '0;
            fill_way_q <= '0;
            fill_pend  <= 1'b0;
            mem_req_q  <= 1'b0;
        end else begin
            mem_req_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    hit_q      <= cacheable ? hit : 2'b00;
                    fill_way_q <= fill_way;
                    if (!req_q.we && cacheable && |hit) begin
                        state <= RESPOND;
                    end else begin
                        state     <= MEM_WAIT;
                        mem_req_q <= 1'b1;
                        fill_pend <= !req_q.we && cacheable;
                    end
                end
                MEM_WAIT: begin
                    if (mem_ack) begin
                        state <= RESPOND;
                    end
                end
                default: begin
                    state     <= IDLE;
                    fill_pend <= 1'b0;
                end
            endcase
        end
    end

    // response word, hit lane or memory data.
    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            rdata <= lane_rdata;
        end else if (state == MEM_WAIT && mem_ack) begin
            rdata <= req_q.we ? '0 : mem_rdata;
        end
    end

    assign busy       = (state != IDLE);
    assign resp_valid = (state == RESPOND);
    assign mem_req    = mem_req_q;

    assign mem_data.we    = req_q.we;
    assign mem_data.addr  = req_q.addr;
    assign mem_data.wdata = req_q.wdata;
    assign mem_data.mask  = req_q.mask;

    assign tag_fill = (state == RESPOND && fill_pend) ? fill_way_q : 2'b00;

    // fill on the response cycle, store merge alongside mem_req.
    always_comb begin
        if (state == RESPOND && fill_pend) begin
            wr_way     = fill_way_q;
            wr_is_fill = 1'b1;
            wr_data    = rdata;
        end else begin
            wr_way     = (mem_req_q && req_q.we) ? hit_q : 2'b00;
            wr_is_fill = 1'b0;
            wr_data    = req_q.wdata;
        end
    end
    assign wr_mask = req_q.mask;

    assert property (@(posedge clk) disable iff (!rst) req |-> !busy)
        else $error("dcache: req while busy");

    assert property (@(posedge clk) disable iff (!rst) mem_ack |-> state == MEM_WAIT)
        else $error("dcache: mem_ack outside MEM_WAIT");

endmodule

// ==== src/dcache_data_sram.sv ====
module dcache_data_sram #(
    parameter int DEPTH = 64,
    parameter int WIDTH = 128
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  logic [WIDTH/8-1:0]       be,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // byte lanes written independently.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < WIDTH / 8; b++) begin
                if (be[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read, old data on a write cycle.
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// ==== src/dcache_lane_mux.sv ====
module dcache_lane_mux (
    input  dcache_pkg::way_sel_t             wr_way,
    input  logic                             wr_is_fill,
    input  logic [dcache_pkg::DATA_W-1:0]    wr_data,
    input  logic [dcache_pkg::DATA_W/8-1:0]  wr_mask,
    input  dcache_pkg::way_sel_t             hit,
    input  logic [2*dcache_pkg::DATA_W-1:0]  sram_rdata,
    output logic                             sram_we,
    output logic [2*dcache_pkg::DATA_W/8-1:0] sram_be,
    output logic [2*dcache_pkg::DATA_W-1:0]  sram_wdata,
    output logic [dcache_pkg::DATA_W-1:0]    lane_rdata
);

    localparam int LANE_W  = dcache_pkg::DATA_W;
    localparam int LANE_BE = dcache_pkg::DATA_W / 8;

    logic [LANE_BE-1:0] lane_be;

    // fills replace the whole word, stores only the strobed bytes.
    always_comb begin
        if (wr_is_fill) begin
            lane_be = '1;
        end else begin
            lane_be = wr_mask;
        end
    end

    // way 0 is the low lane.
    always_comb begin
        sram_we = |wr_way;
        for (int w = 0; w < 2; w++) begin
            sram_wdata[w*LANE_W +: LANE_W] = wr_data;
            if (wr_way[w]) begin
                sram_be[w*LANE_BE +: LANE_BE] = lane_be;
            end else begin
                sram_be[w*LANE_BE +: LANE_BE] = '0;
            end
        end
    end

    // defaults to the low lane when nothing hits.
    always_comb begin
        if (hit[1]) begin
            lane_rdata = sram_rdata[LANE_W +: LANE_W];
        end else begin
            lane_rdata = sram_rdata[0 +: LANE_W];
        end
    end

endmodule

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int INDEX_W  = 6;
    localparam int OFFSET_W = 3;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_SETS = 1 << INDEX_W;

    // field view used by the set lookup.
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } dcache_addr_fields_t;

    // one address word, seen flat or split into fields.
    typedef union packed {
        logic [ADDR_W-1:0]   flat;
        dcache_addr_fields_t fld;
    } dcache_addr_u;

    // core request, 137 bits.
    typedef struct packed {
        logic                we;
        dcache_addr_u        addr;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] mask;
    } dcache_req_t;

    // memory port request, same fields for now.
    typedef struct packed {
        logic                we;
        dcache_addr_u        addr;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] mask;
    } mem_req_t;

    // one-hot, bit 0 is way 0.
    typedef logic [1:0] way_sel_t;

endpackage

// ==== src/dcache_tag_array.sv ====
module dcache_tag_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [dcache_pkg::INDEX_W-1:0] rd_index,
    input  logic [dcache_pkg::TAG_W-1:0]   tag_value,
    input  dcache_pkg::way_sel_t           tag_fill,
    output dcache_pkg::way_sel_t           hit,
    output dcache_pkg::way_sel_t           fill_way
);

    logic [dcache_pkg::NUM_SETS-1:0] valid [2];
    logic [dcache_pkg::TAG_W-1:0]    tags  [2][dcache_pkg::NUM_SETS];
    logic [dcache_pkg::INDEX_W-1:0]  index_q;
    logic [1:0]                      valid_at;

    // index follows the sram read port by one cycle.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            index_q <= '0;
        end else begin
            index_q <= rd_index;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int w = 0; w < 2; w++) begin
                valid[w] <= '0;
                for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
                    tags[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_fill[w]) begin
                    valid[w][index_q] <= 1'b1;
                    tags[w][index_q]  <= tag_value;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            valid_at[w] = valid[w][index_q];
            hit[w]      = valid_at[w] && (tags[w][index_q] == tag_value);
        end
    end

    // invalid way first, else way 0 is the victim.
    always_comb begin
        if (!valid_at[0]) begin
            fill_way = 2'b01;
        end else if (!valid_at[1]) begin
            fill_way = 2'b10;
        end else begin
            fill_way = 2'b01;
        end
    end

    // a tag is only filled on a miss, so both ways never hold it.
    assert property (@(posedge clk) disable iff (!rst) hit != 2'b11)
        else $error("tag array: tag present in both ways");

endmodule

// ==== src/dcache_top.sv ====
module dcache_top #(
    parameter logic [63:0] CACHE_BASE  = 64'h0000_0000_8000_0000,
    parameter logic [63:0] CACHE_LIMIT = 64'h0000_0000_8fff_ffff
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req,
    input  dcache_pkg::dcache_req_t       req_data,
    output logic                          resp_valid,
    output logic [dcache_pkg::DATA_W-1:0] rdata,
    output logic                          busy,
    output logic                          mem_req,
    output dcache_pkg::mem_req_t          mem_data,
    input  logic                          mem_ack,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata
);

    localparam int SRAM_DEPTH = dcache_pkg::NUM_SETS;
    localparam int SRAM_WIDTH = 2 * dcache_pkg::DATA_W;

    logic [dcache_pkg::INDEX_W-1:0]  rd_index;
    logic [dcache_pkg::TAG_W-1:0]    tag_value;
    dcache_pkg::way_sel_t            hit;
    dcache_pkg::way_sel_t            fill_way;
    dcache_pkg::way_sel_t            tag_fill;
    dcache_pkg::way_sel_t            wr_way;
    logic                            wr_is_fill;
    logic [dcache_pkg::DATA_W-1:0]   wr_data;
    logic [dcache_pkg::DATA_W/8-1:0] wr_mask;
    logic [dcache_pkg::DATA_W-1:0]   lane_rdata;
    logic                            sram_we;
    logic [SRAM_WIDTH/8-1:0]         sram_be;
    logic [SRAM_WIDTH-1:0]           sram_wdata;
    logic [SRAM_WIDTH-1:0]           sram_rdata;

    dcache_ctrl #(
        .CACHE_BASE  (CACHE_BASE),
        .CACHE_LIMIT (CACHE_LIMIT)
    ) ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_data   (req_data),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .busy       (busy),
        .mem_req    (mem_req),
        .mem_data   (mem_data),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .rd_index   (rd_index),
        .hit        (hit),
        .fill_way   (fill_way),
        .tag_fill   (tag_fill),
        .tag_value  (tag_value),
        .wr_way     (wr_way),
        .wr_is_fill (wr_is_fill),
        .wr_data    (wr_data),
        .wr_mask    (wr_mask),
        .lane_rdata (lane_rdata)
    );

    dcache_tag_array tags_i (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (rd_index),
        .tag_value (tag_value),
        .tag_fill  (tag_fill),
        .hit       (hit),
        .fill_way  (fill_way)
    );

    dcache_data_sram #(
        .DEPTH (SRAM_DEPTH),
        .WIDTH (SRAM_WIDTH)
    ) sram_i (
        .clk   (clk),
        .addr  (rd_index),
        .we    (sram_we),
        .be    (sram_be),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    dcache_lane_mux lane_i (
        .wr_way     (wr_way),
        .wr_is_fill (wr_is_fill),
        .wr_data    (wr_data),
        .wr_mask    (wr_mask),
        .hit        (hit),
        .sram_rdata (sram_rdata),
        .sram_we    (sram_we),
        .sram_be    (sram_be),
        .sram_wdata (sram_wdata),
        .lane_rdata (lane_rdata)
    );

endmodule
